// ==== all.f ====
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_inv_sbox.sv
source/aes_key_gen.sv
source/aes_round_unit.sv
source/aes_in_ctrl.sv
source/aes_out_buf.sv
source/aes_core.sv
sim/aes_core_asserts.sv
sim/aes_core_tb.sv

// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - files:
      - source/aes_pkg.sv
      - source/aes_sbox.sv
      - source/aes_inv_sbox.sv
      - source/aes_key_gen.sv
      - source/aes_round_unit.sv
      - source/aes_in_ctrl.sv
      - source/aes_out_buf.sv
      - source/aes_core.sv
  - target: simulation
    files:
      - sim/aes_core_asserts.sv
      - sim/aes_core_tb.sv

// ==== sim/aes_core_tb.sv ====
`default_nettype none

module aes_core_tb;

  import aes_pkg::*;

  localparam logic [31:0] SEED = 32'h29a79dcf;
  localparam int NUM_CMDS = 53;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 40 + 200;

  // FIPS-197 example vectors
  localparam block_t KEY_1 = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t PT_1  = 128'h00112233445566778899aabbccddeeff;
  localparam block_t CT_1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam block_t KEY_2 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam block_t PT_2  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam block_t CT_2  = 128'h3925841d02dc09fbdc118597196a0b32;

  logic   clk;
  logic   reset_n;
  logic   in_valid;
  logic   in_ready;
  logic   in_key_ld;
  logic   in_dec;
  block_t in_data;
  logic   out_valid;
  logic   out_ready;
  block_t out_data;

  logic [31:0] rng_state = SEED;
  logic [1:0]  rdy_mode;
  int          errors = 0;
  int          cycles = 0;
  block_t      exp_q[$];
  logic        chk_q[$];
  block_t      ct_q[$];
  block_t      plain [20];
  block_t      rand_key;

  aes_core dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_key_ld(in_key_ld),
    .in_dec   (in_dec),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

  bind aes_core aes_core_asserts u_asserts (
    .clk(clk), .reset_n(reset_n), .in_valid(in_valid), .in_ready(in_ready),
    .in_key_ld(in_key_ld), .in_dec(in_dec), .in_data(in_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic random_block(output block_t blk);
    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      blk[32*i +: 32] = rng_state;
    end
  endtask

  // Holds the command until the edge where in_ready was high
  task automatic send_command(input logic key_ld, input logic dec, input block_t data);
    logic took;
    in_valid  = 1'b1;
    in_key_ld = key_ld;
    in_dec    = dec;
    in_data   = data;
    do begin
      took = in_ready;
      @(posedge clk);
      #1;
    end while (!took);
    in_valid = 1'b0;
  endtask

  task automatic load_key(input block_t key);
    int busy;
    busy = 0;
    send_command(1'b1, 1'b0, key);
    while (!in_ready) begin
      busy++;
      @(posedge clk);
      #1;
    end
    assert (busy == NUM_ROUNDS) else begin
      errors++;
      $display("Fail in_ready low cycles: got %h expected %h", busy, NUM_ROUNDS);
    end
  endtask

  task automatic send_block(input logic dec, input block_t data, input block_t expected,
                            input logic chk);
    exp_q.push_back(expected);
    chk_q.push_back(chk);
    send_command(1'b0, dec, data);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    #1;
  endtask

  // 0 always ready, 1 random, 2 stalled
  always @(posedge clk) begin
    #1;
    case (rdy_mode)
      2'd0: out_ready = 1'b1;
      2'd1: begin
        rng_state = xorshift32(rng_state);
        out_ready = rng_state[3];
      end
      default: out_ready = 1'b0;
    endcase
  end

  // Scoreboard check on each output transfer
  always @(negedge clk) begin
    block_t exp_blk;
    logic   chk;
    if (reset_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output transfer arrived with no result outstanding");
      end else begin
        exp_blk = exp_q.pop_front();
        chk = chk_q.pop_front();
        if (chk) begin
          assert (out_data === exp_blk) else begin
            errors++;
            $display("Fail out_data: got %h expected %h", out_data, exp_blk);
          end
        end else begin
          ct_q.push_back(out_data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    clk       = 1'b0;
    reset_n   = 1'b0;
    in_valid  = 1'b0;
    in_key_ld = 1'b0;
    in_dec    = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    rdy_mode  = 2'd0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    assert (out_valid === 1'b0) else begin
      errors++;
      $display("Fail out_valid after reset: got %h expected %h", out_valid, 1'b0);
    end
    assert (in_ready === 1'b1) else begin
      errors++;
      $display("Fail in_ready after reset: got %h expected %h", in_ready, 1'b1);
    end

    // Known answers, both directions
    load_key(KEY_1);
    send_block(1'b0, PT_1, CT_1, 1'b1);
    send_block(1'b1, CT_1, PT_1, 1'b1);
    load_key(KEY_2);
    send_block(1'b0, PT_2, CT_2, 1'b1);
    send_block(1'b1, CT_2, PT_2, 1'b1);
    wait_drain();

    // Key change while old results sit in a full buffer
    rdy_mode = 2'd2;
    load_key(KEY_1);
    send_block(1'b0, PT_1, CT_1, 1'b1);
    send_block(1'b0, PT_1, CT_1, 1'b1);
    load_key(KEY_2);
    send_block(1'b0, PT_2, CT_2, 1'b1);
    rdy_mode = 2'd0;
    send_block(1'b1, CT_2, PT_2, 1'b1);
    wait_drain();

    // Random round trip, decryption under random back-pressure
    random_block(rand_key);
    load_key(rand_key);
    for (int i = 0; i < 20; i++) begin
      random_block(plain[i]);
      send_block(1'b0, plain[i], '0, 1'b0);
    end
    wait_drain();
    rdy_mode = 2'd1;
    for (int i = 0; i < ct_q.size(); i++) begin
      send_block(1'b1, ct_q[i], plain[i], 1'b1);
    end
    wait_drain();
    rdy_mode = 2'd0;
    repeat (2) @(posedge clk);

    $display("Errors: %0d scoreboard, %0d assertion", errors, dut.u_asserts.assert_errors);
    if (errors == 0 && dut.u_asserts.assert_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/aes_core_asserts.sv ====
`default_nettype none

module aes_core_asserts (
  input logic            clk,
  input logic            reset_n,
  input logic            in_valid,
  input logic            in_ready,
  input logic            in_key_ld,
  input logic            in_dec,
  input aes_pkg::block_t in_data,
  input logic            out_valid,
  input logic            out_ready,
  input aes_pkg::block_t out_data
);

  import aes_pkg::*;

  int          assert_errors = 0;
  int unsigned blocks_in;
  int unsigned results_out;

  // Accepted blocks and delivered results
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      blocks_in   <= 0;
      results_out <= 0;
    end else begin
      if (in_valid && in_ready && !in_key_ld) blocks_in <= blocks_in + 1;
      if (out_valid && out_ready) results_out <= results_out + 1;
    end
  end

  reset_no_output: assert property (@(posedge clk) !reset_n |-> !out_valid)
    else begin
      assert_errors++;
      $error("out_valid is high during reset");
    end

  // Stalled result holds
  out_hold: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      assert_errors++;
      $error("out_data or out_valid changed while the output was stalled");
    end

  in_hold: assert property (@(posedge clk) disable iff (!reset_n)
    in_valid && !in_ready |=> in_valid && $stable({in_key_ld, in_dec, in_data}))
    else begin
      assert_errors++;
      $error("Command changed while waiting for in_ready");
    end

  // Never more results than blocks
  no_extra_output: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid && out_ready |-> results_out < blocks_in)
    else begin
      assert_errors++;
      $error("More output transfers than accepted blocks");
    end

endmodule

`default_nettype wire

// ==== source/aes_core.sv ====
`default_nettype none

module aes_core (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  logic            in_key_ld,
  input  logic            in_dec,
  input  aes_pkg::block_t in_data,
  output logic            out_valid,
  input  logic            out_ready,
  output aes_pkg::block_t out_data
);

  import aes_pkg::*;

  logic   key_ld, key_en, dec_en;
  rnd_t   rnd_num;
  block_t key_in;
  block_t round_key;
  block_t blk;
  logic   st_ld, st_en, st_last;
  block_t state;
  logic   res_push;
  logic   buf_free;

  aes_in_ctrl u_in_ctrl (
    .clk      (clk),
    .reset_n  (reset_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_key_ld(in_key_ld),
    .in_dec   (in_dec),
    .in_data  (in_data),
    .buf_free (buf_free),
    .round_key(round_key),
    .key_ld   (key_ld),
    .key_en   (key_en),
    .dec_en   (dec_en),
    .rnd_num  (rnd_num),
    .key_in   (key_in),
    .blk_out  (blk),
    .st_ld    (st_ld),
    .st_en    (st_en),
    .st_last  (st_last),
    .res_push (res_push)
  );

  aes_key_gen u_key_gen (
    .clk    (clk),
    .reset_n(reset_n),
    .key_in (key_in),
    .key_ld (key_ld),
    .key_en (key_en),
    .dec_en (dec_en),
    .rnd_num(rnd_num),
    .key_out(round_key)
  );

  // Round direction follows the key direction
  aes_round_unit u_round_unit (
    .clk      (clk),
    .reset_n  (reset_n),
    .blk_in   (blk),
    .round_key(round_key),
    .st_ld    (st_ld),
    .st_en    (st_en),
    .st_last  (st_last),
    .dec      (dec_en),
    .state    (state)
  );

  aes_out_buf u_out_buf (
    .clk      (clk),
    .reset_n  (reset_n),
    .res_push (res_push),
    .res_data (state),
    .buf_free (buf_free),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// ==== source/aes_out_buf.sv ====
`default_nettype none

module aes_out_buf (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            res_push,
  input  aes_pkg::block_t res_data,
  output logic            buf_free,
  output logic            out_valid,
  input  logic            out_ready,
  output aes_pkg::block_t out_data
);

  import aes_pkg::*;

  block_t     mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       pop;

  assign pop       = out_valid && out_ready;
  assign buf_free  = (count < 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (res_push) begin
      mem[wr_ptr] <= res_data;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (res_push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      // Simultaneous push and pop leaves the count alone
      case ({res_push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/aes_in_ctrl.sv ====
`default_nettype none

module aes_in_ctrl (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  logic            in_key_ld,
  input  logic            in_dec,
  input  aes_pkg::block_t in_data,
  input  logic            buf_free,
  input  aes_pkg::block_t round_key,
  output logic            key_ld,
  output logic            key_en,
  output logic            dec_en,
  output aes_pkg::rnd_t   rnd_num,
  output aes_pkg::block_t key_in,
  output aes_pkg::block_t blk_out,
  output logic            st_ld,
  output logic            st_en,
  output logic            st_last,
  output logic            res_push
);

  import aes_pkg::*;

  ctrl_state_t state_q;
  rnd_t        rnd_q;
  logic        dec_q;
  block_t      enc_key_q;
  block_t      last_key_q;
  logic        accept;
  logic        busy;
  logic        last;

  assign in_ready = (state_q == IDLE);
  assign accept   = in_valid && in_ready;
  assign busy     = (state_q == KEY_EXPAND) || (state_q == RUN);
  assign last     = (rnd_q == rnd_t'(NUM_ROUNDS));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= IDLE;
      rnd_q   <= '0;
      dec_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= in_key_ld ? KEY_EXPAND : RUN;
            rnd_q   <= rnd_t'(1);
            dec_q   <= in_dec && !in_key_ld;
          end
        end
        KEY_EXPAND, RUN: begin
          if (last) begin
            state_q <= (state_q == RUN) ? EMIT : IDLE;
            rnd_q   <= '0;
          end else begin
            rnd_q <= rnd_q + 1'b1;
          end
        end
        // Hold the result until the buffer has room
        EMIT: begin
          if (buf_free) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Cipher key on load, final round key at the end of expansion
  always_ff @(posedge clk) begin
    if (accept && in_key_ld) begin
      enc_key_q <= in_data;
    end
    if ((state_q == KEY_EXPAND) && last) begin
      last_key_q <= round_key;
    end
  end

  assign key_ld   = accept;
  assign key_en   = accept || (busy && !last);
  assign dec_en   = in_ready ? (in_dec && !in_key_ld) : dec_q;
  assign rnd_num  = rnd_q;
  assign key_in   = in_key_ld ? in_data : (in_dec ? last_key_q : enc_key_q);
  assign blk_out  = in_data;
  assign st_ld    = accept && !in_key_ld;
  assign st_en    = (state_q == RUN);
  assign st_last  = st_en && last;
  assign res_push = (state_q == EMIT) && buf_free;

endmodule

`default_nettype wire

// ==== source/aes_round_unit.sv ====
`default_nettype none

module aes_round_unit (
  input  logic            clk,
  input  logic            reset_n,
  input  aes_pkg::block_t blk_in,
  input  aes_pkg::block_t round_key,
  input  logic            st_ld,
  input  logic            st_en,
  input  logic            st_last,
  input  logic            dec,
  output aes_pkg::block_t state
);

  import aes_pkg::*;

  block_t sub_fwd;
  block_t sub_inv;
  block_t enc_sr;
  block_t enc_next;
  block_t dec_ark;
  block_t dec_next;

  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic word_t mix_col(input word_t w);
    byte_t a0, a1, a2, a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // Inverse column mix as a x4 pre-step followed by the forward mix
  function automatic word_t inv_mix_col(input word_t w);
    byte_t u, v;
    u = xtime(xtime(w[31:24] ^ w[15:8]));
    v = xtime(xtime(w[23:16] ^ w[7:0]));
    return mix_col(w ^ {u, v, u, v});
  endfunction

  function automatic block_t mix_block(input block_t b, input logic inv);
    block_t res;
    for (int c = 0; c < 4; c++) begin
      res[127-32*c -: 32] = inv ? inv_mix_col(b[127-32*c -: 32]) : mix_col(b[127-32*c -: 32]);
    end
    return res;
  endfunction

  // Byte (row r, column c) sits at index 4c + r
  function automatic block_t shift_rows(input block_t b, input logic inv);
    block_t res;
    int     src;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        src = inv ? (c + 4 - r) % 4 : (c + r) % 4;
        res[127-8*(4*c+r) -: 8] = b[127-8*(4*src+r) -: 8];
      end
    end
    return res;
  endfunction

  // Substitution before the row shift, both orders give the same bytes
  for (genvar i = 0; i < 16; i++) begin : g_sub
    aes_sbox u_sbox (
      .sbox_in (state[127-8*i -: 8]),
      .sbox_out(sub_fwd[127-8*i -: 8])
    );
    aes_inv_sbox u_inv_sbox (
      .sbox_in (state[127-8*i -: 8]),
      .sbox_out(sub_inv[127-8*i -: 8])
    );
  end

  assign enc_sr   = shift_rows(sub_fwd, 1'b0);
  assign enc_next = (st_last ? enc_sr : mix_block(enc_sr, 1'b0)) ^ round_key;

  assign dec_ark  = shift_rows(sub_inv, 1'b1) ^ round_key;
  assign dec_next = st_last ? dec_ark : mix_block(dec_ark, 1'b1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= '0;
    end else if (st_ld) begin
      // Initial AddRoundKey
      state <= blk_in ^ round_key;
    end else if (st_en) begin
      state <= dec ? dec_next : enc_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/aes_key_gen.sv ====
`default_nettype none

module aes_key_gen (
  input  logic            clk,
  input  logic            reset_n,
  input  aes_pkg::block_t key_in,
  input  logic            key_ld,
  input  logic            key_en,
  input  logic            dec_en,
  input  aes_pkg::rnd_t   rnd_num,
  output aes_pkg::block_t key_out
);

  import aes_pkg::*;

  // Forward steps keep words 1..3 one round behind word 0
  block_t key_q;
  logic   dec_q;

  byte_t  rcon;
  byte_t  rcon_inv;
  word_t  w1_nxt, w2_nxt, w3_nxt;
  word_t  fw0, fw1, fw2, fw3;
  word_t  fw0_nxt;
  block_t src_b;
  word_t  b0, b1, b2, b3;
  word_t  sbox_in;
  word_t  rot_word;
  word_t  sub_word;

  function automatic byte_t rcon_of(input rnd_t idx);
    case (idx)
      4'd0:    return 8'h01;
      4'd1:    return 8'h02;
      4'd2:    return 8'h04;
      4'd3:    return 8'h08;
      4'd4:    return 8'h10;
      4'd5:    return 8'h20;
      4'd6:    return 8'h40;
      4'd7:    return 8'h80;
      4'd8:    return 8'h1b;
      default: return 8'h36;
    endcase
  endfunction

  // Backward steps walk the constants in reverse
  assign rcon     = rcon_of(rnd_num);
  assign rcon_inv = rcon_of(rnd_t'(NUM_ROUNDS - 1) - rnd_num);

  // Complete the lagging words of the current key
  assign w1_nxt = key_q[127:96] ^ key_q[95:64];
  assign w2_nxt = w1_nxt ^ key_q[63:32];
  assign w3_nxt = w2_nxt ^ key_q[31:0];

  assign fw0 = key_ld ? key_in[127:96] : key_q[127:96];
  assign fw1 = key_ld ? key_in[95:64]  : w1_nxt;
  assign fw2 = key_ld ? key_in[63:32]  : w2_nxt;
  assign fw3 = key_ld ? key_in[31:0]   : w3_nxt;
  assign fw0_nxt = fw0 ^ sub_word ^ {rcon, 24'h000000};

  // Inverse expansion from the full current key
  assign src_b = key_ld ? key_in : key_q;
  assign b3 = src_b[31:0]  ^ src_b[63:32];
  assign b2 = src_b[63:32] ^ src_b[95:64];
  assign b1 = src_b[95:64] ^ src_b[127:96];
  assign b0 = src_b[127:96] ^ sub_word ^ {rcon_inv, 24'h000000};

  // SubWord(RotWord) shared by both directions
  assign sbox_in  = dec_en ? b3 : fw3;
  assign rot_word = {sbox_in[23:0], sbox_in[31:24]};

  for (genvar i = 0; i < 4; i++) begin : g_sbox
    aes_sbox u_sbox (
      .sbox_in (rot_word[8*i +: 8]),
      .sbox_out(sub_word[8*i +: 8])
    );
  end

  always_ff @(posedge clk) begin
    if (key_en) begin
      key_q <= dec_en ? {b0, b1, b2, b3} : {fw0_nxt, fw1, fw2, fw3};
    end
  end

  // Direction of the last step picks the output arrangement
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dec_q <= 1'b0;
    end else if (key_en) begin
      dec_q <= dec_en;
    end
  end

  assign key_out = key_ld ? key_in :
                   dec_q  ? key_q  : {key_q[127:96], w1_nxt, w2_nxt, w3_nxt};

endmodule

`default_nettype wire

// ==== source/aes_inv_sbox.sv ====
`default_nettype none

module aes_inv_sbox (
  input  aes_pkg::byte_t sbox_in,
  output aes_pkg::byte_t sbox_out
);

  // Inverse S-box, same layout as the forward table
  localparam logic [0:255][7:0] INV_SBOX = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  assign sbox_out = INV_SBOX[sbox_in];

endmodule

`default_nettype wire

// ==== source/aes_sbox.sv ====
`default_nettype none

module aes_sbox (
  input  aes_pkg::byte_t sbox_in,
  output aes_pkg::byte_t sbox_out
);

  // Forward S-box, row 0 holds entries 00 to 0f
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  assign sbox_out = SBOX[sbox_in];

endmodule

`default_nettype wire

// ==== source/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  // AES-128 round count
  localparam int NUM_ROUNDS = 10;

  localparam int BLOCK_W = 128;
  localparam int WORD_W  = 32;
  localparam int BYTE_W  = 8;
  localparam int RND_W   = 4;

  // Block, cipher key or round key
  typedef logic [BLOCK_W-1:0] block_t;

  // One state column or key word
  typedef logic [WORD_W-1:0] word_t;

  // S-box input and output
  typedef logic [BYTE_W-1:0] byte_t;

  // Round number, 0 to NUM_ROUNDS
  typedef logic [RND_W-1:0] rnd_t;

  // Control FSM
  typedef enum logic [1:0] {
    IDLE,
    KEY_EXPAND,
    RUN,
    EMIT
  } ctrl_state_t;

endpackage

`default_nettype wire
